// File: verilog.f
hw/ctrl_pkg.sv
hw/decode_if.sv
hw/ctrl_decoder.sv
hw/ctrl_sequencer.sv
hw/ctrl_signal_encoder.sv
hw/control_unit.sv
tb/tb_control_unit.sv

// File: tb/tb_control_unit.sv
`timescale 1ns/1ps

module tb_control_unit;

    localparam int MEM_LAT   = 2;
    localparam int NUM_TESTS = 200;
    localparam int TIMEOUT   = NUM_TESTS * 9 + 16;

    // codes outside the kept set
    localparam logic [23:0] BAD_OPS = {6'h0f, 6'h20, 6'h28, 6'h3f};
    localparam logic [23:0] BAD_FNS = {6'h00, 6'h18, 6'h21, 6'h25};

    typedef enum {
        k_boot, k_add, k_sub, k_and, k_slt, k_addi, k_addiu, k_slti,
        k_lw, k_sw, k_beq, k_bne, k_j, k_jal, k_bad_op, k_bad_fn
    } kind_t;

    logic                    clk = 1'b0;
    logic                    rst;
    ctrl_pkg::opcode_t       opcode;
    ctrl_pkg::funct_t        funct;
    logic                    overflow;
    logic                    pc_write, pc_write_cond, ir_write, mem_write, mdr_write;
    logic                    a_write, b_write, alu_out_write, reg_write, epc_write;
    ctrl_pkg::branch_cond_t  branch_cond;
    ctrl_pkg::mem_addr_sel_t mem_addr_sel;
    ctrl_pkg::pc_src_t       pc_src;
    ctrl_pkg::alu_src_a_t    alu_src_a;
    ctrl_pkg::alu_src_b_t    alu_src_b;
    ctrl_pkg::alu_op_t       alu_op;
    ctrl_pkg::reg_dst_t      reg_dst;
    ctrl_pkg::wb_src_t       wb_src;
    ctrl_pkg::exc_cause_t    exc_cause;
    logic [9:0]              strobes;

    // reference model, phase counts cycles from ir_write
    kind_t             kind = k_boot;
    int                phase = -1;
    int                len = 2;         // sp_init to first ir_write
    int                prev_len = 0;
    int                fetch_gap = 0;
    logic              is_reg = 1'b0;
    logic              is_alu = 1'b0;
    logic              trap = 1'b0;
    logic              is_illegal = 1'b0;
    ctrl_pkg::alu_op_t exp_op = ctrl_pkg::alu_add;
    logic [31:0]       lfsr = 32'hfe18_6807;
    int                cycle = 0;
    int                err_count = 0;
    int                err_at_start = 0;
    int                tests_done = 0;
    int                tests_bad = 0;

    control_unit #(.MEM_LATENCY(MEM_LAT)) u_dut (.*);

    assign strobes = {pc_write, pc_write_cond, ir_write, mem_write, mdr_write,
                      a_write, b_write, alu_out_write, reg_write, epc_write};

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == TIMEOUT) begin
            $display("run hung: no instruction fetch seen within %0d cycles", cycle);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic flag_error(input string msg);
        err_count++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic pick_instr();
        logic [7:0] sel;
        logic [7:0] rnd_fn;
        logic [7:0] idx;
        logic [7:0] ovf;
        draw_bits(4, sel);
        draw_bits(6, rnd_fn);
        draw_bits(2, idx);
        draw_bits(1, ovf);
        kind     = (sel[3:0] == 4'd15) ? k_bad_op : kind_t'(int'(sel[3:0]) + 1);
        overflow = ovf[0];
        opcode   = ctrl_pkg::OP_RTYPE;
        funct    = rnd_fn[5:0];   // don't care outside r-type
        case (kind)
            k_add:    funct  = ctrl_pkg::FN_ADD;
            k_sub:    funct  = ctrl_pkg::FN_SUB;
            k_and:    funct  = ctrl_pkg::FN_AND;
            k_slt:    funct  = ctrl_pkg::FN_SLT;
            k_bad_fn: funct  = BAD_FNS[idx[1:0] * 6 +: 6];
            k_addi:   opcode = ctrl_pkg::OP_ADDI;
            k_addiu:  opcode = ctrl_pkg::OP_ADDIU;
            k_slti:   opcode = ctrl_pkg::OP_SLTI;
            k_lw:     opcode = ctrl_pkg::OP_LW;
            k_sw:     opcode = ctrl_pkg::OP_SW;
            k_beq:    opcode = ctrl_pkg::OP_BEQ;
            k_bne:    opcode = ctrl_pkg::OP_BNE;
            k_j:      opcode = ctrl_pkg::OP_J;
            k_jal:    opcode = ctrl_pkg::OP_JAL;
            default:  opcode = BAD_OPS[idx[1:0] * 6 +: 6];
        endcase
        is_reg     = kind inside {k_add, k_sub, k_and, k_slt};
        is_alu     = is_reg || (kind inside {k_addi, k_addiu, k_slti});
        trap       = overflow && (kind inside {k_add, k_sub, k_addi});
        is_illegal = kind inside {k_bad_op, k_bad_fn};
        case (kind)
            k_sub:         exp_op = ctrl_pkg::alu_sub;
            k_and:         exp_op = ctrl_pkg::alu_and;
            k_slt, k_slti: exp_op = ctrl_pkg::alu_slt;
            default:       exp_op = ctrl_pkg::alu_add;
        endcase
        // last state, then fetch1 and fetch2
        if (trap)
            len = 6 + MEM_LAT;
        else if (is_illegal || kind == k_lw)
            len = 5 + MEM_LAT;
        else if (kind inside {k_beq, k_bne, k_j})
            len = 4;
        else
            len = 5;
    endtask

    task automatic finish_test();
        tests_done++;
        if (err_count != err_at_start)
            tests_bad++;
        $display("test %0d %s overflow=%0b: %s", tests_done, kind.name(), overflow,
                 (err_count == err_at_start) ? "ok" : "FAILED");
        err_at_start = err_count;
    endtask

    initial begin
        rst      = 1'b1;
        opcode   = '0;
        funct    = '0;
        overflow = 1'b0;
        repeat (16) @(posedge clk);
        #0.5 rst = 1'b0;
        @(posedge clk);
        #0.5 phase = 0;   // st_sp_init
        while (tests_done < NUM_TESTS) begin
            @(posedge clk);
            #0.5;
            if (ir_write) begin
                if (kind != k_boot)
                    finish_test();
                fetch_gap = phase + 1;
                prev_len  = len;
                phase     = 0;
                pick_instr();   // fields go with ir_write, like a real ir
            end else begin
                phase++;
            end
        end
        @(posedge clk);
        #0.5;
        $display("run %0d, bad %0d, check errors %0d", tests_done, tests_bad, err_count);
        if (err_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    a_reset_quiet: assert property (@(posedge clk) rst && cycle > 0 |-> strobes == '0)
        else flag_error("write strobe high during reset");

    a_sp_init: assert property (@(posedge clk) disable iff (rst)
        kind == k_boot && phase == 0 |-> reg_write && reg_dst == ctrl_pkg::dst_sp
            && wb_src == ctrl_pkg::wb_sp_init)
        else flag_error("no stack pointer load after reset");

    a_fetch_gap: assert property (@(posedge clk) disable iff (rst)
        ir_write |-> fetch_gap == prev_len)
        else flag_error("ir_write out of step with the previous instruction");

    // register read and branch target at k+1
    a_decode: assert property (@(posedge clk) disable iff (rst)
        kind != k_boot && phase == 1 |-> a_write && b_write && alu_out_write
            && alu_src_a == ctrl_pkg::srca_pc && alu_src_b == ctrl_pkg::srcb_imm_shifted)
        else flag_error("decode cycle strobes wrong at k+1");

    a_alu_exec: assert property (@(posedge clk) disable iff (rst)
        is_alu && phase == 2 |-> alu_op == exp_op && alu_out_write
            && alu_src_a == ctrl_pkg::srca_reg_a
            && alu_src_b == (is_reg ? ctrl_pkg::srcb_reg_b : ctrl_pkg::srcb_imm))
        else flag_error("wrong alu operation at k+2");

    a_alu_wb: assert property (@(posedge clk) disable iff (rst)
        is_alu && !trap && phase == 3 |-> reg_write && wb_src == ctrl_pkg::wb_alu_out
            && reg_dst == (is_reg ? ctrl_pkg::dst_rd : ctrl_pkg::dst_rt))
        else flag_error("alu writeback missing at k+3");

    a_ovf_epc: assert property (@(posedge clk) disable iff (rst)
        trap && phase == 3 |-> epc_write && exc_cause == ctrl_pkg::cause_overflow && !reg_write)
        else flag_error("overflow trap did not save epc at k+3");

    a_exc_vector: assert property (@(posedge clk) disable iff (rst)
        (trap && phase == 4 + MEM_LAT) || (is_illegal && phase == 3 + MEM_LAT)
            |-> pc_write && pc_src == ctrl_pkg::pcsrc_mdr)
        else flag_error("handler address not loaded into pc");

    a_opc_epc: assert property (@(posedge clk) disable iff (rst)
        is_illegal && phase == 2 |-> epc_write && exc_cause == ctrl_pkg::cause_opcode)
        else flag_error("illegal instruction did not save epc at k+2");

    a_epc_only: assert property (@(posedge clk) disable iff (rst)
        epc_write |-> (trap && phase == 3) || (is_illegal && phase == 2))
        else flag_error("unexpected epc_write");

    a_lw_read: assert property (@(posedge clk) disable iff (rst)
        kind == k_lw && phase == 2 + MEM_LAT
            |-> mdr_write && mem_addr_sel == ctrl_pkg::addr_alu_out)
        else flag_error("lw data not captured in mdr");

    a_lw_wb: assert property (@(posedge clk) disable iff (rst)
        kind == k_lw && phase == 3 + MEM_LAT |-> reg_write
            && wb_src == ctrl_pkg::wb_mdr && reg_dst == ctrl_pkg::dst_rt)
        else flag_error("lw writeback missing");

    a_sw: assert property (@(posedge clk) disable iff (rst)
        kind == k_sw && phase == 3 |-> mem_write && mem_addr_sel == ctrl_pkg::addr_alu_out)
        else flag_error("sw did not write memory at k+3");

    a_branch: assert property (@(posedge clk) disable iff (rst)
        (kind == k_beq || kind == k_bne) && phase == 2 |-> pc_write_cond
            && branch_cond == (kind == k_bne ? ctrl_pkg::br_ne : ctrl_pkg::br_eq))
        else flag_error("branch strobe or condition wrong at k+2");

    a_jump: assert property (@(posedge clk) disable iff (rst)
        (kind == k_j && phase == 2) || (kind == k_jal && phase == 3)
            |-> pc_write && pc_src == ctrl_pkg::pcsrc_jump_target)
        else flag_error("jump target not written to pc");

    a_jal_link: assert property (@(posedge clk) disable iff (rst)
        kind == k_jal && phase == 2 |-> reg_write && reg_dst == ctrl_pkg::dst_ra
            && wb_src == ctrl_pkg::wb_pc)
        else flag_error("jal did not link ra at k+2");

endmodule

// File: hw/control_unit.sv
`timescale 1ns/1ps

module control_unit #(
    parameter int MEM_LATENCY = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  ctrl_pkg::opcode_t       opcode,
    input  ctrl_pkg::funct_t        funct,
    input  logic                    overflow,
    output logic                    pc_write,
    output logic                    pc_write_cond,
    output logic                    ir_write,
    output logic                    mem_write,
    output logic                    mdr_write,
    output logic                    a_write,
    output logic                    b_write,
    output logic                    alu_out_write,
    output logic                    reg_write,
    output logic                    epc_write,
    output ctrl_pkg::branch_cond_t  branch_cond,
    output ctrl_pkg::mem_addr_sel_t mem_addr_sel,
    output ctrl_pkg::pc_src_t       pc_src,
    output ctrl_pkg::alu_src_a_t    alu_src_a,
    output ctrl_pkg::alu_src_b_t    alu_src_b,
    output ctrl_pkg::alu_op_t       alu_op,
    output ctrl_pkg::reg_dst_t      reg_dst,
    output ctrl_pkg::wb_src_t       wb_src,
    output ctrl_pkg::exc_cause_t    exc_cause
);

    ctrl_pkg::ctrl_state_t state;

    decode_if dec_bus ();

    ctrl_decoder u_decoder (
        .opcode (opcode),
        .funct  (funct),
        .dec    (dec_bus)
    );

    ctrl_sequencer #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_sequencer (
        .clk      (clk),
        .rst      (rst),
        .overflow (overflow),
        .dec      (dec_bus),
        .state    (state)
    );

    ctrl_signal_encoder u_encoder (
        .state         (state),
        .dec           (dec_bus),
        .pc_write      (pc_write),
        .pc_write_cond (pc_write_cond),
        .ir_write      (ir_write),
        .mem_write     (mem_write),
        .mdr_write     (mdr_write),
        .a_write       (a_write),
        .b_write       (b_write),
        .alu_out_write (alu_out_write),
        .reg_write     (reg_write),
        .epc_write     (epc_write),
        .branch_cond   (branch_cond),
        .mem_addr_sel  (mem_addr_sel),
        .pc_src        (pc_src),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .reg_dst       (reg_dst),
        .wb_src        (wb_src),
        .exc_cause     (exc_cause)
    );

endmodule

// File: hw/ctrl_signal_encoder.sv
`timescale 1ns/1ps

module ctrl_signal_encoder (
    input  ctrl_pkg::ctrl_state_t   state,
    decode_if.enc                   dec,
    output logic                    pc_write,
    output logic                    pc_write_cond,
    output logic                    ir_write,
    output logic                    mem_write,
    output logic                    mdr_write,
    output logic                    a_write,
    output logic                    b_write,
    output logic                    alu_out_write,
    output logic                    reg_write,
    output logic                    epc_write,
    output ctrl_pkg::branch_cond_t  branch_cond,
    output ctrl_pkg::mem_addr_sel_t mem_addr_sel,
    output ctrl_pkg::pc_src_t       pc_src,
    output ctrl_pkg::alu_src_a_t    alu_src_a,
    output ctrl_pkg::alu_src_b_t    alu_src_b,
    output ctrl_pkg::alu_op_t       alu_op,
    output ctrl_pkg::reg_dst_t      reg_dst,
    output ctrl_pkg::wb_src_t       wb_src,
    output ctrl_pkg::exc_cause_t    exc_cause
);

    always_comb begin
        pc_write      = 1'b0;
        pc_write_cond = 1'b0;
        ir_write      = 1'b0;
        mem_write     = 1'b0;
        mdr_write     = 1'b0;
        a_write       = 1'b0;
        b_write       = 1'b0;
        alu_out_write = 1'b0;
        reg_write     = 1'b0;
        epc_write     = 1'b0;
        branch_cond   = dec.branch_cond;
        mem_addr_sel  = ctrl_pkg::addr_pc;
        pc_src        = ctrl_pkg::pcsrc_alu_result;
        alu_src_a     = ctrl_pkg::srca_pc;
        alu_src_b     = ctrl_pkg::srcb_four;
        alu_op        = ctrl_pkg::alu_add;
        reg_dst       = ctrl_pkg::dst_rt;
        wb_src        = ctrl_pkg::wb_alu_out;
        exc_cause     = ctrl_pkg::cause_overflow;

        case (state)
            ctrl_pkg::st_sp_init: begin
                reg_write = 1'b1;
                reg_dst   = ctrl_pkg::dst_sp;
                wb_src    = ctrl_pkg::wb_sp_init;
            end
            ctrl_pkg::st_fetch2: begin   // pc + 4 straight from the alu
                pc_write = 1'b1;
                ir_write = 1'b1;
            end
            ctrl_pkg::st_decode: begin
                a_write       = 1'b1;
                b_write       = 1'b1;
                alu_out_write = 1'b1;
                alu_src_b     = ctrl_pkg::srcb_imm_shifted;   // branch target
            end
            ctrl_pkg::st_alu_exec: begin
                alu_src_a     = ctrl_pkg::srca_reg_a;
                alu_src_b     = dec.uses_imm ? ctrl_pkg::srcb_imm : ctrl_pkg::srcb_reg_b;
                alu_op        = dec.alu_op;
                alu_out_write = 1'b1;
            end
            ctrl_pkg::st_alu_wb: begin
                reg_write = 1'b1;
                if (dec.cls == ctrl_pkg::cls_alu_reg)
                    reg_dst = ctrl_pkg::dst_rd;
            end
            ctrl_pkg::st_mem_addr: begin
                alu_src_a     = ctrl_pkg::srca_reg_a;
                alu_src_b     = ctrl_pkg::srcb_imm;
                alu_out_write = 1'b1;
            end
            ctrl_pkg::st_mem_read: begin
                mem_addr_sel = ctrl_pkg::addr_alu_out;
                mdr_write    = 1'b1;   // last cycle holds the data
            end
            ctrl_pkg::st_load_wb: begin
                reg_write = 1'b1;
                wb_src    = ctrl_pkg::wb_mdr;
            end
            ctrl_pkg::st_mem_write: begin
                mem_addr_sel = ctrl_pkg::addr_alu_out;
                mem_write    = 1'b1;
            end
            ctrl_pkg::st_branch: begin
                alu_src_a     = ctrl_pkg::srca_reg_a;
                alu_src_b     = ctrl_pkg::srcb_reg_b;
                alu_op        = ctrl_pkg::alu_sub;
                pc_write_cond = 1'b1;
                pc_src        = ctrl_pkg::pcsrc_alu_out;
            end
            ctrl_pkg::st_jump: begin
                pc_write = 1'b1;
                pc_src   = ctrl_pkg::pcsrc_jump_target;
            end
            ctrl_pkg::st_jal_link: begin
                reg_write = 1'b1;
                reg_dst   = ctrl_pkg::dst_ra;
                wb_src    = ctrl_pkg::wb_pc;
            end
            // epc gets pc - 4, the faulting instruction
            ctrl_pkg::st_exc_ovf, ctrl_pkg::st_exc_opc: begin
                epc_write = 1'b1;
                alu_op    = ctrl_pkg::alu_sub;
                if (state == ctrl_pkg::st_exc_opc)
                    exc_cause = ctrl_pkg::cause_opcode;
            end
            ctrl_pkg::st_exc_load: begin
                mem_addr_sel = ctrl_pkg::addr_exc_vector;
                mdr_write    = 1'b1;
            end
            ctrl_pkg::st_exc_vector: begin
                pc_write = 1'b1;
                pc_src   = ctrl_pkg::pcsrc_mdr;
            end
            default: ;   // st_reset and st_fetch1 keep the defaults
        endcase
    end

endmodule

// File: hw/ctrl_sequencer.sv
`timescale 1ns/1ps

module ctrl_sequencer #(
    parameter int MEM_LATENCY = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  overflow,
    decode_if.seq                 dec,
    output ctrl_pkg::ctrl_state_t state
);

    ctrl_pkg::ctrl_state_t next_state;
    ctrl_pkg::wait_count_t wait_cnt;
    logic                  waiting;
    logic                  wait_done;

    // memory access and handler fetch both stall for the memory latency
    assign waiting   = (state == ctrl_pkg::st_mem_read) || (state == ctrl_pkg::st_exc_load);
    assign wait_done = (wait_cnt == ctrl_pkg::wait_count_t'(MEM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ctrl_pkg::st_reset;
            wait_cnt <= '0;
        end else begin
            state <= next_state;
            if (waiting && !wait_done)
                wait_cnt <= wait_cnt + 1'b1;
            else
                wait_cnt <= '0;   // ready for the next wait
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ctrl_pkg::st_reset:   next_state = ctrl_pkg::st_sp_init;
            ctrl_pkg::st_sp_init: next_state = ctrl_pkg::st_fetch1;
            ctrl_pkg::st_fetch1:  next_state = ctrl_pkg::st_fetch2;
            ctrl_pkg::st_fetch2:  next_state = ctrl_pkg::st_decode;

            ctrl_pkg::st_decode: begin
                case (dec.cls)
                    ctrl_pkg::cls_alu_reg,
                    ctrl_pkg::cls_alu_imm: next_state = ctrl_pkg::st_alu_exec;
                    ctrl_pkg::cls_load,
                    ctrl_pkg::cls_store:   next_state = ctrl_pkg::st_mem_addr;
                    ctrl_pkg::cls_branch:  next_state = ctrl_pkg::st_branch;
                    ctrl_pkg::cls_jump:    next_state = ctrl_pkg::st_jump;
                    ctrl_pkg::cls_jal:     next_state = ctrl_pkg::st_jal_link;
                    default:               next_state = ctrl_pkg::st_exc_opc;
                endcase
            end

            // overflow flag is valid while the alu computes
            ctrl_pkg::st_alu_exec: begin
                if (overflow && dec.traps_overflow)
                    next_state = ctrl_pkg::st_exc_ovf;
                else
                    next_state = ctrl_pkg::st_alu_wb;
            end

            ctrl_pkg::st_mem_addr: begin
                if (dec.cls == ctrl_pkg::cls_load)
                    next_state = ctrl_pkg::st_mem_read;
                else
                    next_state = ctrl_pkg::st_mem_write;
            end

            ctrl_pkg::st_mem_read: begin
                if (wait_done)
                    next_state = ctrl_pkg::st_load_wb;
            end

            ctrl_pkg::st_jal_link: next_state = ctrl_pkg::st_jump;   // link first, then jump

            ctrl_pkg::st_exc_ovf,
            ctrl_pkg::st_exc_opc:  next_state = ctrl_pkg::st_exc_load;

            ctrl_pkg::st_exc_load: begin
                if (wait_done)
                    next_state = ctrl_pkg::st_exc_vector;
            end

            // alu_wb, load_wb, mem_write, branch, jump, exc_vector end the instruction
            default: next_state = ctrl_pkg::st_fetch1;
        endcase
    end

endmodule

// File: hw/ctrl_decoder.sv
`timescale 1ns/1ps

module ctrl_decoder (
    input  ctrl_pkg::opcode_t opcode,
    input  ctrl_pkg::funct_t  funct,
    decode_if.producer        dec
);

    always_comb begin
        dec.cls            = ctrl_pkg::cls_illegal;
        dec.alu_op         = ctrl_pkg::alu_add;
        dec.traps_overflow = 1'b0;
        dec.branch_cond    = ctrl_pkg::br_eq;
        dec.uses_imm       = 1'b0;

        case (opcode)
            ctrl_pkg::OP_RTYPE: begin
                dec.cls = ctrl_pkg::cls_alu_reg;
                case (funct)
                    ctrl_pkg::FN_ADD: dec.traps_overflow = 1'b1;
                    ctrl_pkg::FN_SUB: begin
                        dec.alu_op         = ctrl_pkg::alu_sub;
                        dec.traps_overflow = 1'b1;
                    end
                    ctrl_pkg::FN_AND: dec.alu_op = ctrl_pkg::alu_and;
                    ctrl_pkg::FN_SLT: dec.alu_op = ctrl_pkg::alu_slt;
                    default:          dec.cls = ctrl_pkg::cls_illegal;   // unknown funct
                endcase
            end
            ctrl_pkg::OP_ADDI: begin
                dec.cls            = ctrl_pkg::cls_alu_imm;
                dec.traps_overflow = 1'b1;
                dec.uses_imm       = 1'b1;
            end
            ctrl_pkg::OP_ADDIU: begin
                dec.cls      = ctrl_pkg::cls_alu_imm;   // no trap
                dec.uses_imm = 1'b1;
            end
            ctrl_pkg::OP_SLTI: begin
                dec.cls      = ctrl_pkg::cls_alu_imm;
                dec.alu_op   = ctrl_pkg::alu_slt;
                dec.uses_imm = 1'b1;
            end
            ctrl_pkg::OP_LW: begin
                dec.cls      = ctrl_pkg::cls_load;
                dec.uses_imm = 1'b1;
            end
            ctrl_pkg::OP_SW: begin
                dec.cls      = ctrl_pkg::cls_store;
                dec.uses_imm = 1'b1;
            end
            ctrl_pkg::OP_BEQ, ctrl_pkg::OP_BNE: begin
                dec.cls    = ctrl_pkg::cls_branch;
                dec.alu_op = ctrl_pkg::alu_sub;   // compare by subtraction
                if (opcode == ctrl_pkg::OP_BNE)
                    dec.branch_cond = ctrl_pkg::br_ne;
            end
            ctrl_pkg::OP_J:   dec.cls = ctrl_pkg::cls_jump;
            ctrl_pkg::OP_JAL: dec.cls = ctrl_pkg::cls_jal;
            default:          dec.cls = ctrl_pkg::cls_illegal;
        endcase
    end

endmodule

// File: hw/decode_if.sv
`timescale 1ns/1ps

interface decode_if;

    ctrl_pkg::instr_class_t cls;
    ctrl_pkg::alu_op_t      alu_op;
    logic                   traps_overflow;    // add, sub, addi
    ctrl_pkg::branch_cond_t branch_cond;
    logic                   uses_imm;

    modport producer (
        output cls, alu_op, traps_overflow, branch_cond, uses_imm
    );

    modport seq (input cls, traps_overflow);

    modport enc (input alu_op, branch_cond, uses_imm, cls);

endinterface

// File: hw/ctrl_pkg.sv
package ctrl_pkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [3:0] wait_count_t;   // memory wait cycles, up to 15

    // major opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // r-type funct field
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        cls_alu_reg, cls_alu_imm, cls_load, cls_store,
        cls_branch, cls_jump, cls_jal, cls_illegal
    } instr_class_t;

    typedef enum logic [1:0] {alu_add, alu_sub, alu_and, alu_slt} alu_op_t;

    typedef enum logic {br_eq, br_ne} branch_cond_t;

    typedef enum logic [4:0] {
        st_reset, st_sp_init, st_fetch1, st_fetch2, st_decode,
        st_alu_exec, st_alu_wb,
        st_mem_addr, st_mem_read, st_load_wb, st_mem_write,
        st_branch, st_jump, st_jal_link,
        st_exc_ovf, st_exc_opc, st_exc_load, st_exc_vector
    } ctrl_state_t;

    // datapath mux selects
    typedef enum logic [1:0] {addr_pc, addr_alu_out, addr_exc_vector} mem_addr_sel_t;

    typedef enum logic [1:0] {
        pcsrc_alu_result, pcsrc_alu_out, pcsrc_jump_target, pcsrc_mdr
    } pc_src_t;

    typedef enum logic {srca_pc, srca_reg_a} alu_src_a_t;

    typedef enum logic [1:0] {
        srcb_reg_b, srcb_four, srcb_imm, srcb_imm_shifted
    } alu_src_b_t;

    typedef enum logic [1:0] {dst_rt, dst_rd, dst_ra, dst_sp} reg_dst_t;

    typedef enum logic [1:0] {wb_alu_out, wb_mdr, wb_pc, wb_sp_init} wb_src_t;

    typedef enum logic {cause_overflow, cause_opcode} exc_cause_t;

endpackage
